// File: Bender.yml
package:
  name: cpu_pipeline

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/isaPkg.sv
      - source/pipePkg.sv
      - source/fetchStage.sv
      - source/decodeStage.sv
      - source/executeStage.sv
      - source/memoryStage.sv
      - source/cpuTop.sv

  - target: test
    files:
      - tb/cpuTb.sv

// File: build.f
+incdir+include
source/isaPkg.sv
source/pipePkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/cpuTop.sv
tb/cpuTb.sv

// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath and storage sizes
`define DATA_W      32
`define REG_CNT     32
`define IMEM_DEPTH  256
`define DMEM_DEPTH  256
`define ALU_OP_W    4

// Primary opcodes
`define OP_RTYPE    6'h00
`define OP_J        6'h02
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDI     6'h08
`define OP_LW       6'h23
`define OP_SW       6'h2B
`define OP_HALT     6'h3F

// R-type funct field
`define FN_ADD      6'h20
`define FN_SUB      6'h22
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2A

// ALU operations
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_SLT     4'd4

`endif

// File: source/cpuTop.sv
module cpuTop
   import isaPkg::*;
   import pipePkg::*;
(
   input  logic     Clk,
   input  logic     rstN,
   input  logic     progReq,
   input  imemAddrT progAddr,
   input  wordT     progData,
   output logic     progAck,
   input  logic     run,
   output logic     wbValid,
   output regIdxT   wbReg,
   output wordT     wbData,
   output logic     halted
);

   // Fetch to decode
   wordT   ifInstr;
   wordT   ifPcNext;
   logic   ifValid;
   logic   haltSeen;

   // Decode to execute
   wordT   idA;
   wordT   idB;
   wordT   idImm;
   regIdxT idDest;
   aluOpT  idAluOp;
   logic   idAluSrc;
   logic   idMemRead;
   logic   idMemWrite;
   logic   idRegWrite;
   logic   idBranchEq;
   logic   idBranchNe;
   logic   idJump;
   logic   idHalt;
   wordT   idPcNext;
   logic   idValid;

   // Execute to memory and back to the front end
   logic   redirect;
   wordT   redirectPc;
   wordT   exResult;
   wordT   exStore;
   regIdxT exDest;
   logic   exMemRead;
   logic   exMemWrite;
   logic   exRegWrite;
   logic   exHalt;
   logic   exValid;

   fetchStage fetchStage_i (
      .Clk        (Clk),
      .rstN       (rstN),
      .run        (run),
      .progReq    (progReq),
      .progAddr   (progAddr),
      .progData   (progData),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .stop       (haltSeen),
      .progAck    (progAck),
      .ifInstr    (ifInstr),
      .ifPcNext   (ifPcNext),
      .ifValid    (ifValid)
   );

   // Write-back feeds the register file and the retire port alike
   decodeStage decodeStage_i (
      .Clk        (Clk),
      .rstN       (rstN),
      .ifInstr    (ifInstr),
      .ifPcNext   (ifPcNext),
      .ifValid    (ifValid),
      .flush      (redirect),
      .wbWe       (wbValid),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .idA        (idA),
      .idB        (idB),
      .idImm      (idImm),
      .idDest     (idDest),
      .idAluOp    (idAluOp),
      .idAluSrc   (idAluSrc),
      .idMemRead  (idMemRead),
      .idMemWrite (idMemWrite),
      .idRegWrite (idRegWrite),
      .idBranchEq (idBranchEq),
      .idBranchNe (idBranchNe),
      .idJump     (idJump),
      .idHalt     (idHalt),
      .idPcNext   (idPcNext),
      .idValid    (idValid),
      .haltSeen   (haltSeen)
   );

   executeStage executeStage_i (
      .Clk        (Clk),
      .rstN       (rstN),
      .idA        (idA),
      .idB        (idB),
      .idImm      (idImm),
      .idDest     (idDest),
      .idAluOp    (idAluOp),
      .idAluSrc   (idAluSrc),
      .idMemRead  (idMemRead),
      .idMemWrite (idMemWrite),
      .idRegWrite (idRegWrite),
      .idBranchEq (idBranchEq),
      .idBranchNe (idBranchNe),
      .idJump     (idJump),
      .idHalt     (idHalt),
      .idPcNext   (idPcNext),
      .idValid    (idValid),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .exResult   (exResult),
      .exStore    (exStore),
      .exDest     (exDest),
      .exMemRead  (exMemRead),
      .exMemWrite (exMemWrite),
      .exRegWrite (exRegWrite),
      .exHalt     (exHalt),
      .exValid    (exValid)
   );

   memoryStage memoryStage_i (
      .Clk        (Clk),
      .rstN       (rstN),
      .exResult   (exResult),
      .exStore    (exStore),
      .exDest     (exDest),
      .exMemRead  (exMemRead),
      .exMemWrite (exMemWrite),
      .exRegWrite (exRegWrite),
      .exHalt     (exHalt),
      .exValid    (exValid),
      .wbWe       (wbValid),
      .wbReg      (wbReg),
      .wbData     (wbData),
      .halted     (halted)
   );

endmodule

// File: source/decodeStage.sv
`include "cpu_settings.svh"

module decodeStage
   import isaPkg::*;
   import pipePkg::*;
(
   input  logic   Clk,
   input  logic   rstN,
   input  wordT   ifInstr,
   input  wordT   ifPcNext,
   input  logic   ifValid,
   input  logic   flush,
   input  logic   wbWe,
   input  regIdxT wbReg,
   input  wordT   wbData,
   output wordT   idA,
   output wordT   idB,
   output wordT   idImm,
   output regIdxT idDest,
   output aluOpT  idAluOp,
   output logic   idAluSrc,
   output logic   idMemRead,
   output logic   idMemWrite,
   output logic   idRegWrite,
   output logic   idBranchEq,
   output logic   idBranchNe,
   output logic   idJump,
   output logic   idHalt,
   output wordT   idPcNext,
   output logic   idValid,
   output logic   haltSeen
);

   wordT   regs [`REG_CNT];
   opcodeT opcode;
   functT  funct;
   regIdxT rs;
   regIdxT rt;
   regIdxT rd;
   immT    imm;
   wordT   immExt;
   aluOpT  aluOp;
   logic   aluSrc;
   logic   memRead;
   logic   memWrite;
   logic   regWrite;
   logic   branchEq;
   logic   branchNe;
   logic   jump;
   logic   isHalt;
   logic   destRd;
   logic   haltNow;
   logic   haltLatch;

   assign opcode = ifInstr[31:26];
   assign rs     = ifInstr[25:21];
   assign rt     = ifInstr[20:16];
   assign rd     = ifInstr[15:11];
   assign imm    = ifInstr[15:0];
   assign funct  = ifInstr[5:0];

   // J carries its 26-bit index in the immediate slot
   assign immExt = jump ? {6'b0, ifInstr[25:0]} : {{(`DATA_W-16){imm[15]}}, imm};

   //////////////////////////////
   // Control decoder
   //////////////////////////////

   always_comb begin
      aluOp    = `ALU_ADD;
      aluSrc   = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      regWrite = 1'b0;
      branchEq = 1'b0;
      branchNe = 1'b0;
      jump     = 1'b0;
      isHalt   = 1'b0;
      destRd   = 1'b0;
      case (opcode)
         `OP_RTYPE: begin
            destRd   = 1'b1;
            regWrite = 1'b1;
            case (funct)
               `FN_ADD: aluOp = `ALU_ADD;
               `FN_SUB: aluOp = `ALU_SUB;
               `FN_AND: aluOp = `ALU_AND;
               `FN_OR:  aluOp = `ALU_OR;
               `FN_SLT: aluOp = `ALU_SLT;
               // All-zero word lands here and acts as a NOP
               default: regWrite = 1'b0;
            endcase
         end
         `OP_ADDI: begin
            aluSrc   = 1'b1;
            regWrite = 1'b1;
         end
         `OP_LW: begin
            aluSrc   = 1'b1;
            memRead  = 1'b1;
            regWrite = 1'b1;
         end
         `OP_SW: begin
            aluSrc   = 1'b1;
            memWrite = 1'b1;
         end
         `OP_BEQ:  branchEq = 1'b1;
         `OP_BNE:  branchNe = 1'b1;
         `OP_J:    jump     = 1'b1;
         `OP_HALT: isHalt   = 1'b1;
         default:  ;
      endcase
   end

   //////////////////////////////
   // Register file
   //////////////////////////////

   always_ff @(posedge Clk) begin
      if (wbWe && wbReg != '0) begin
         regs[wbReg] <= wbData;
      end
   end

   // Same-cycle write-back is passed straight through
   function automatic wordT readReg(input regIdxT idx);
      wordT val;
      if (idx == '0) val = '0;
      else if (wbWe && wbReg == idx) val = wbData;
      else val = regs[idx];
      return val;
   endfunction

   //////////////////////////////
   // ID/EX and halt tracking
   //////////////////////////////

   always_ff @(posedge Clk) begin
      if (!rstN) begin
         idValid <= 1'b0;
      end else begin
         idValid <= ifValid && !flush;
      end
   end

   always_ff @(posedge Clk) begin
      idA        <= readReg(rs);
      idB        <= readReg(rt);
      idImm      <= immExt;
      idDest     <= destRd ? rd : rt;
      idAluOp    <= aluOp;
      idAluSrc   <= aluSrc;
      idMemRead  <= memRead;
      idMemWrite <= memWrite;
      idRegWrite <= regWrite;
      idBranchEq <= branchEq;
      idBranchNe <= branchNe;
      idJump     <= jump;
      idHalt     <= isHalt;
      idPcNext   <= ifPcNext;
   end

   // A HALT behind a taken branch does not count
   assign haltNow = ifValid && !flush && isHalt;

   always_ff @(posedge Clk) begin
      if (!rstN) begin
         haltLatch <= 1'b0;
      end else if (haltNow) begin
         haltLatch <= 1'b1;
      end
   end

   assign haltSeen = haltNow || haltLatch;

   regZeroNeverWritten: assert property (
      @(posedge Clk) disable iff (!rstN) wbWe |-> wbReg != '0);

endmodule

// File: source/executeStage.sv
`include "cpu_settings.svh"

module executeStage
   import isaPkg::*;
   import pipePkg::*;
(
   input  logic   Clk,
   input  logic   rstN,
   input  wordT   idA,
   input  wordT   idB,
   input  wordT   idImm,
   input  regIdxT idDest,
   input  aluOpT  idAluOp,
   input  logic   idAluSrc,
   input  logic   idMemRead,
   input  logic   idMemWrite,
   input  logic   idRegWrite,
   input  logic   idBranchEq,
   input  logic   idBranchNe,
   input  logic   idJump,
   input  logic   idHalt,
   input  wordT   idPcNext,
   input  logic   idValid,
   output logic   redirect,
   output wordT   redirectPc,
   output wordT   exResult,
   output wordT   exStore,
   output regIdxT exDest,
   output logic   exMemRead,
   output logic   exMemWrite,
   output logic   exRegWrite,
   output logic   exHalt,
   output logic   exValid
);

   wordT  opB;
   wordT  aluOut;
   wordT  branchTarget;
   wordT  jumpTarget;
   logic  live;
   logic  haltGone;
   pcSelT pcSel;

   // Nothing younger than a HALT goes on
   assign live = idValid && !haltGone;
   assign opB  = idAluSrc ? idImm : idB;

   always_comb begin
      case (idAluOp)
         `ALU_ADD: aluOut = idA + opB;
         `ALU_SUB: aluOut = idA - opB;
         `ALU_AND: aluOut = idA & opB;
         `ALU_OR:  aluOut = idA | opB;
         `ALU_SLT: aluOut = {{(`DATA_W-1){1'b0}}, $signed(idA) < $signed(opB)};
         default:  aluOut = '0;
      endcase
   end

   //////////////////////////////
   // Branch and jump resolution
   //////////////////////////////

   assign branchTarget = idPcNext + {idImm[`DATA_W-3:0], 2'b00};
   assign jumpTarget   = {idPcNext[`DATA_W-1:28], idImm[25:0], 2'b00};

   always_comb begin
      pcSel = seqPc;
      if (live) begin
         if (idJump) pcSel = jumpPc;
         else if (idBranchEq && idA == idB) pcSel = branchPc;
         else if (idBranchNe && idA != idB) pcSel = branchPc;
      end
   end

   assign redirect   = (pcSel != seqPc);
   assign redirectPc = (pcSel == jumpPc) ? jumpTarget : branchTarget;

   //////////////////////////////
   // EX/MEM
   //////////////////////////////

   always_ff @(posedge Clk) begin
      if (!rstN) begin
         exValid  <= 1'b0;
         haltGone <= 1'b0;
      end else begin
         exValid <= live;
         if (live && idHalt) haltGone <= 1'b1;
      end
   end

   always_ff @(posedge Clk) begin
      exResult   <= aluOut;
      exStore    <= idB;
      exDest     <= idDest;
      exMemRead  <= idMemRead;
      exMemWrite <= idMemWrite;
      exRegWrite <= idRegWrite;
      exHalt     <= idHalt;
   end

endmodule

// File: source/fetchStage.sv
`include "cpu_settings.svh"

module fetchStage
   import isaPkg::*;
   import pipePkg::*;
(
   input  logic     Clk,
   input  logic     rstN,
   input  logic     run,
   input  logic     progReq,
   input  imemAddrT progAddr,
   input  wordT     progData,
   input  logic     redirect,
   input  wordT     redirectPc,
   input  logic     stop,
   output logic     progAck,
   output wordT     ifInstr,
   output wordT     ifPcNext,
   output logic     ifValid
);

   wordT      imem [`IMEM_DEPTH];
   wordT      pc;
   wordT      pcPlus4;
   imemAddrT  fetchIdx;
   loadStateT loadState;

   //////////////////////////////
   // Program loader
   //////////////////////////////

   // Requests are ignored once the core runs
   always_ff @(posedge Clk) begin
      if (!rstN) begin
         loadState <= idle;
      end else begin
         case (loadState)
            idle:     if (progReq && !run) loadState <= write;
            write:    loadState <= waitDrop;
            waitDrop: if (!progReq) loadState <= idle;
            default:  loadState <= idle;
         endcase
      end
   end

   // Loader holds address and data until it sees the ack
   always_ff @(posedge Clk) begin
      if (loadState == write) begin
         imem[progAddr] <= progData;
      end
   end

   assign progAck = (loadState != idle);

   //////////////////////////////
   // PC and IF/ID
   //////////////////////////////

   assign pcPlus4  = pc + wordT'(4);
   assign fetchIdx = pc[$bits(imemAddrT)+1:2];

   always_ff @(posedge Clk) begin
      if (!rstN) begin
         pc <= '0;
      end else if (run) begin
         if (redirect) pc <= redirectPc;
         else if (!stop) pc <= pcPlus4;
      end
   end

   // Slot is squashed by a redirect from execute
   always_ff @(posedge Clk) begin
      if (!rstN) begin
         ifValid <= 1'b0;
      end else begin
         ifValid <= run && !stop && !redirect;
      end
   end

   always_ff @(posedge Clk) begin
      ifInstr  <= imem[fetchIdx];
      ifPcNext <= pcPlus4;
   end

   ackHeldUntilReqDrops: assert property (
      @(posedge Clk) disable iff (!rstN) $fell(progAck) |-> !progReq);

endmodule

// File: source/isaPkg.sv
`include "cpu_settings.svh"

package isaPkg;

   // Machine word and register index
   typedef logic [`DATA_W-1:0]              wordT;
   typedef logic [$clog2(`REG_CNT)-1:0]     regIdxT;

   // Instruction fields
   typedef logic [5:0]                      opcodeT;
   typedef logic [5:0]                      functT;
   typedef logic [15:0]                     immT;

   // Word address into instruction memory
   typedef logic [$clog2(`IMEM_DEPTH)-1:0]  imemAddrT;

endpackage

// File: source/memoryStage.sv
`include "cpu_settings.svh"

module memoryStage
   import isaPkg::*;
(
   input  logic   Clk,
   input  logic   rstN,
   input  wordT   exResult,
   input  wordT   exStore,
   input  regIdxT exDest,
   input  logic   exMemRead,
   input  logic   exMemWrite,
   input  logic   exRegWrite,
   input  logic   exHalt,
   input  logic   exValid,
   output logic   wbWe,
   output regIdxT wbReg,
   output wordT   wbData,
   output logic   halted
);

   localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

   wordT               dmem [`DMEM_DEPTH];
   logic [DMEM_AW-1:0] dAddr;
   logic               memRe;
   logic               memWe;
   wordT               loadData;

   // Word addressed, low two bits ignored
   assign dAddr    = exResult[DMEM_AW+1:2];
   assign memRe    = exValid && exMemRead;
   assign memWe    = exValid && exMemWrite;
   assign loadData = dmem[dAddr];

   always_ff @(posedge Clk) begin
      if (memWe) begin
         dmem[dAddr] <= exStore;
      end
   end

   //////////////////////////////
   // MEM/WB and retire
   //////////////////////////////

   always_ff @(posedge Clk) begin
      if (!rstN) begin
         wbWe   <= 1'b0;
         halted <= 1'b0;
      end else begin
         wbWe <= exValid && exRegWrite && (exDest != '0);
         // Sticky until reset
         if (exValid && exHalt) halted <= 1'b1;
      end
   end

   always_ff @(posedge Clk) begin
      wbReg  <= exDest;
      wbData <= memRe ? loadData : exResult;
   end

   readWriteExclusive: assert property (
      @(posedge Clk) disable iff (!rstN) !(memRe && memWe));

endmodule

// File: source/pipePkg.sv
`include "cpu_settings.svh"

package pipePkg;

   typedef logic [`ALU_OP_W-1:0] aluOpT;

   // Loader side of the program handshake
   typedef enum logic [1:0] {
      idle,
      write,
      waitDrop
   } loadStateT;

   // Where the next PC comes from
   typedef enum logic [1:0] {
      seqPc,
      branchPc,
      jumpPc
   } pcSelT;

endpackage

// File: tb/cpuStimulus.txt
// Program: word count (decimal), then one instruction word per line (hex)
// Expected: write-back count (decimal), then register (decimal) and value (hex)
32
20010005  addi r1, r0, 5
2002FFFD  addi r2, r0, -3
20037FFF  addi r3, r0, 0x7fff
2005FFFF  addi r5, r0, -1
00222020  add  r4, r1, r2
00413022  sub  r6, r2, r1
0041382A  slt  r7, r2, r1
0022402A  slt  r8, r1, r2
00654824  and  r9, r3, r5
00435025  or   r10, r2, r3
00A15820  add  r11, r5, r1
AC030008  sw   r3, 8(r0)
AC06000C  sw   r6, 12(r0)
8C0C0008  lw   r12, 8(r0)
8C0D000C  lw   r13, 12(r0)
10210002  beq  r1, r1, +2 taken
200E0111  addi r14, r0, 0x111 skipped
200E0222  addi r14, r0, 0x222 skipped
14220002  bne  r1, r2, +2 taken
200F0333  addi r15, r0, 0x333 skipped
200F0444  addi r15, r0, 0x444 skipped
10220005  beq  r1, r2, +5 falls through
14210005  bne  r1, r1, +5 falls through
20100055  addi r16, r0, 0x55
0800001B  j    27
20110666  addi r17, r0, 0x666 skipped
20110777  addi r17, r0, 0x777 skipped
20120012  addi r18, r0, 0x12
018D9820  add  r19, r12, r13
FC000000  halt
20140099  addi r20, r0, 0x99 behind halt
201400AA  addi r20, r0, 0xaa behind halt
16
1 00000005
2 FFFFFFFD
3 00007FFF
5 FFFFFFFF
4 00000002
6 FFFFFFF8
7 00000001
8 00000000
9 00007FFF
10 FFFFFFFF
11 00000004
12 00007FFF
13 FFFFFFF8
16 00000055
18 00000012
19 00007FF7

// File: tb/cpuTb.sv
module cpuTb
   import isaPkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   logic     Clk = 1'b0;
   logic     rstN;
   logic     progReq;
   imemAddrT progAddr;
   wordT     progData;
   logic     progAck;
   logic     run;
   logic     wbValid;
   regIdxT   wbReg;
   wordT     wbData;
   logic     halted;

   // Program image and expected retire stream
   wordT     progWords [$];
   regIdxT   expRegs [$];
   wordT     expVals [$];
   int       expIdx = 0;
   int       watchdogCycles = 0;
   logic     ackSeen = 1'b0;

   always #2 Clk = ~Clk;

   cpuTop cpuTop_i (
      .Clk      (Clk),
      .rstN     (rstN),
      .progReq  (progReq),
      .progAddr (progAddr),
      .progData (progData),
      .progAck  (progAck),
      .run      (run),
      .wbValid  (wbValid),
      .wbReg    (wbReg),
      .wbData   (wbData),
      .halted   (halted)
   );

   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("Finished with errors");
      $fatal(1, "run stopped at the first error");
   endtask

   //////////////////////////////
   // Stimulus file
   //////////////////////////////

   // Skips blank lines and full-line comments
   task automatic readDataLine(input int fd, output string line);
      string raw;
      int    rc;
      line = "";
      while (line == "" && !$feof(fd)) begin
         rc = $fgets(raw, fd);
         if (rc > 0 && raw.len() > 1 && raw.substr(0, 1) != "//") line = raw;
      end
      if (line == "") reportFailure("stimulus file ended before all entries were read");
   endtask

   task automatic readStimulus();
      int    fd;
      int    rc;
      int    count;
      int    regNum;
      wordT  value;
      string line;
      fd = $fopen("tb/cpuStimulus.txt", "r");
      if (fd == 0) reportFailure("could not open the stimulus file tb/cpuStimulus.txt");
      readDataLine(fd, line);
      rc = $sscanf(line, "%d", count);
      assert (rc == 1) else reportFailure("program length line is malformed");
      for (int i = 0; i < count; i++) begin
         readDataLine(fd, line);
         rc = $sscanf(line, "%h", value);
         assert (rc == 1) else reportFailure($sformatf("program word %0d is malformed", i));
         progWords.push_back(value);
      end
      readDataLine(fd, line);
      rc = $sscanf(line, "%d", count);
      assert (rc == 1) else reportFailure("expected count line is malformed");
      for (int i = 0; i < count; i++) begin
         readDataLine(fd, line);
         rc = $sscanf(line, "%d %h", regNum, value);
         assert (rc == 2) else reportFailure($sformatf("expected pair %0d is malformed", i));
         expRegs.push_back(regIdxT'(regNum));
         expVals.push_back(value);
      end
      $fclose(fd);
   endtask

   //////////////////////////////
   // Loader and checkers
   //////////////////////////////

   // Four-phase handshake with address and data held until the ack drops
   task automatic loadWord(input int idx, input wordT word);
      @(posedge Clk);
      progReq  <= 1'b1;
      progAddr <= imemAddrT'(idx);
      progData <= word;
      @(negedge Clk);
      while (progAck !== 1'b1) @(negedge Clk);
      @(posedge Clk);
      progReq <= 1'b0;
      @(negedge Clk);
      while (progAck !== 1'b0) @(negedge Clk);
   endtask

   always @(negedge Clk) begin
      if (rstN) begin
         if (progAck && !ackSeen) begin
            assert (progReq) else reportFailure("progAck rose while progReq was low");
         end
         if (!progAck && ackSeen) begin
            assert (!progReq) else reportFailure("progAck fell while progReq was still high");
         end
         ackSeen = progAck;
      end
   end

   always @(negedge Clk) begin
      if (rstN && wbValid === 1'b1) begin
         assert (run) else reportFailure("write-back occurred while run was low");
         assert (expIdx < expVals.size())
            else reportFailure($sformatf("unexpected write-back to r%0d after the list ended",
                                         wbReg));
         if (expIdx < expVals.size()) begin
            assert (wbReg == expRegs[expIdx])
               else reportFailure($sformatf("mismatch wbReg: got 0x%h, expected 0x%h (entry %0d)",
                                            wbReg, expRegs[expIdx], expIdx));
            assert (wbData == expVals[expIdx])
               else reportFailure($sformatf("mismatch wbData: got 0x%h, expected 0x%h (entry %0d)",
                                            wbData, expVals[expIdx], expIdx));
            expIdx++;
         end
      end
   end

   // Limit scales with program length and retire count
   initial begin
      wait (watchdogCycles > 0);
      repeat (watchdogCycles) @(posedge Clk);
      reportFailure($sformatf("timeout: program did not halt within %0d cycles", watchdogCycles));
   end

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      rstN     = 1'b0;
      progReq  = 1'b0;
      progAddr = '0;
      progData = '0;
      run      = 1'b0;
      readStimulus();
      watchdogCycles = progWords.size() * 8 + expVals.size() * 12 + 200;
      repeat (3) @(posedge Clk);
      rstN <= 1'b1;
      @(negedge Clk);
      assert (progAck === 1'b0) else reportFailure("progAck is not low after reset");
      assert (wbValid === 1'b0) else reportFailure("wbValid is not low after reset");
      assert (halted === 1'b0) else reportFailure("halted is not low after reset");
      for (int i = 0; i < progWords.size(); i++) begin
         loadWord(i, progWords[i]);
      end
      @(posedge Clk);
      run <= 1'b1;
      @(negedge Clk);
      while (halted !== 1'b1) @(negedge Clk);
      assert (expIdx == expVals.size())
         else reportFailure($sformatf("halted after only %0d of %0d expected write-backs",
                                      expIdx, expVals.size()));
      // Anything retiring behind the HALT is caught by the checker
      repeat (20) @(negedge Clk);
      assert (halted === 1'b1) else reportFailure("halted dropped before reset");
      $display("Finished with no errors");
      $finish;
   end

endmodule
